//--- Makefile
SIM      = verilator
TOP      = tb_img_ctrl
FILELIST = verilog.f
FLAGS    = --binary --timing --assert -j 0
OBJ_DIR  = obj_dir

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out=$$(./$(OBJ_DIR)/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "ALL TESTS PASSED"

lint:
	$(SIM) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- src/capture_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module capture_ctrl
    import img_ctrl_pkg::*;
(
    input  wire                  clk,
    input  wire                  fifoIn_rst,
    input  wire cmd_t            cmd,
    input  wire img_bus_t        img,
    input  wire                  rd_done,
    output ctrl_state_e          state,
    output logic                 block,
    output logic [HEADER_W-1:0]  header,
    output logic                 capture_start,
    output logic                 hdr_load,
    output logic                 hdr_phase,
    output logic                 pix_phase,
    output logic                 rd_start,
    output logic                 capture_done
);

    // Header words still to emit
    logic [HDR_CNT_W-1:0] hdr_cnt;

    // Sampled frame-valid levels
    logic fv_low;
    logic fv_high;

    assign fv_low  = img.valid && !img.fv;
    assign fv_high = img.valid && img.fv;

    // ==================================================
    // Command decode
    // ==================================================
    // Only accepted in IDLE
    assign capture_start = (state == IDLE) && cmd.capture;
    // Capture wins if both arrive together
    assign rd_start      = (state == IDLE) && cmd.readout && !cmd.capture;

    // Datapath phases
    assign hdr_phase = (state == HEADER);
    assign pix_phase = (state == PIXELS);

    // Header held for the framer
    always_ff @(posedge clk) begin
        if (capture_start) begin
            header <= cmd.header;
        end
    end

    // ==================================================
    // Control FSM
    // ==================================================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            state        <= IDLE;
            block        <= 1'b0;
            hdr_cnt      <= '0;
            hdr_load     <= 1'b0;
            capture_done <= 1'b0;
        end else begin
            // Single-cycle strobes
            hdr_load     <= 1'b0;
            capture_done <= 1'b0;

            case (state)
                IDLE: begin
                    if (cmd.capture) begin
                        state <= ARM;
                        block <= cmd.block;
                    end else if (cmd.readout) begin
                        state <= READOUT;
                        block <= cmd.block;
                    end
                end
                // Need a frame gap before syncing
                ARM: begin
                    if (fv_low) begin
                        state    <= WAIT_FRAME;
                        hdr_load <= 1'b1;
                    end
                end
                WAIT_FRAME: begin
                    if (fv_high) begin
                        state   <= HEADER;
                        hdr_cnt <= HDR_CNT_W'(HEADER_WORDS - 1);
                    end
                end
                // One header word per cycle
                HEADER: begin
                    hdr_cnt <= hdr_cnt - 1'b1;
                    if (hdr_cnt == '0) begin
                        state <= PIXELS;
                    end
                end
                // First gap sample closes the frame
                PIXELS: begin
                    if (fv_low) begin
                        state        <= IDLE;
                        capture_done <= 1'b1;
                    end
                end
                READOUT: begin
                    if (rd_done) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // Never write header and pixels in the same cycle
    assert property (@(posedge clk) disable iff (!fifoIn_rst)
        !(hdr_phase && pix_phase));

    // Buffer finishes only a readout started here
    assert property (@(posedge clk) disable iff (!fifoIn_rst)
        rd_done |-> (state == READOUT));

endmodule

`default_nettype wire

//--- src/frame_buffer.sv
`timescale 1ns/1ns
`default_nettype none

module frame_buffer
    import img_ctrl_pkg::*;
(
    input  wire                       clk,
    input  wire                       fifoIn_rst,
    input  wire                       block,
    input  wire                       capture_start,
    input  wire word_wr_t             wr,
    input  wire                       rd_start,
    output logic [WORD_COUNT_W-1:0]   wr_count,
    output readout_t                  readout,
    output logic                      rd_done
);

    // Both blocks in one array, block is the top address bit
    logic [WORD_W-1:0] mem [BLOCK_COUNT*BLOCK_WORDS];

    // Write accepted while the block has room
    logic wr_ok;

    // Readout streamer
    logic                    rd_active;
    logic [WORD_COUNT_W-1:0] rd_ptr;
    logic                    rd_valid_q;
    logic [WORD_W-1:0]       rd_word_q;

    assign wr_ok = wr.en && (wr_count < WORD_COUNT_W'(BLOCK_WORDS));

    // ==================================================
    // Memory
    // ==================================================
    always_ff @(posedge clk) begin
        if (wr_ok) begin
            mem[{block, wr_count[BLOCK_ADDR_W-1:0]}] <= wr.word;
        end
        if (rd_active) begin
            rd_word_q <= mem[{block, rd_ptr[BLOCK_ADDR_W-1:0]}];
        end
    end

    // Write pointer doubles as stored length
    always_ff @(posedge clk) begin
        if (!fifoIn_rst || capture_start) begin
            wr_count <= '0;
        end else if (wr_ok) begin
            wr_count <= wr_count + 1'b1;
        end
    end

    // ==================================================
    // Readout
    // ==================================================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            rd_active  <= 1'b0;
            rd_ptr     <= '0;
            rd_valid_q <= 1'b0;
            rd_done    <= 1'b0;
        end else begin
            rd_valid_q <= rd_active;
            // Empty block finishes at once
            rd_done    <= (rd_start && (wr_count == '0)) || (rd_valid_q && !rd_active);
            if (rd_start) begin
                rd_active <= (wr_count != '0);
                rd_ptr    <= '0;
            end else if (rd_active) begin
                rd_ptr <= rd_ptr + 1'b1;
                // Last word issued
                if (rd_ptr == wr_count - 1'b1) begin
                    rd_active <= 1'b0;
                end
            end
        end
    end

    assign readout = '{valid: rd_valid_q, word: rd_word_q};

    // Capture and readout never overlap
    assert property (@(posedge clk) disable iff (!fifoIn_rst)
        rd_active |-> !wr.en);

endmodule

`default_nettype wire

//--- src/img_ctrl_pkg.sv
`default_nettype none

package img_ctrl_pkg;

    // ==================================================
    // Sizes
    // ==================================================
    localparam int PIXEL_W       = 12;
    localparam int WORD_W        = 16;
    localparam int HEADER_W      = 64;
    localparam int HEADER_WORDS  = 4;
    localparam int HDR_CNT_W     = 2;
    localparam int BLOCK_WORDS   = 4096;
    localparam int BLOCK_ADDR_W  = 12;
    localparam int BLOCK_COUNT   = 2;
    localparam int WORD_COUNT_W  = 13;
    localparam int STAT_W        = 18;
    localparam int STAT_TOP_BITS = 7;

    // Controller states
    typedef enum logic [2:0] {
        IDLE,
        ARM,
        WAIT_FRAME,
        HEADER,
        PIXELS,
        READOUT
    } ctrl_state_e;

    // ==================================================
    // Bundles
    // ==================================================
    // Host command
    typedef struct packed {
        logic                capture;
        logic                readout;
        logic                block;
        logic [HEADER_W-1:0] header;
    } cmd_t;

    // Camera pixel bus, sampled on valid
    typedef struct packed {
        logic               valid;
        logic               fv;
        logic               lv;
        logic [PIXEL_W-1:0] pixel;
    } img_bus_t;

    // One storage write
    typedef struct packed {
        logic              en;
        logic [WORD_W-1:0] word;
    } word_wr_t;

    // Status seen by the host
    typedef struct packed {
        logic                    capture_done;
        logic [WORD_COUNT_W-1:0] word_count;
        logic [STAT_W-1:0]       highlight_count;
        logic [STAT_W-1:0]       shadow_count;
    } status_t;

    // One readout word
    typedef struct packed {
        logic              valid;
        logic [WORD_W-1:0] word;
    } readout_t;

endpackage

`default_nettype wire

//--- src/img_ctrl_top.sv
`timescale 1ns/1ns
`default_nettype none

module img_ctrl_top
    import img_ctrl_pkg::*;
(
    input  wire           clk,
    input  wire           fifoIn_rst,
    input  wire cmd_t     cmd,
    input  wire img_bus_t img,
    output status_t       status,
    output readout_t      readout
);

    // ==================================================
    // Control to datapath
    // ==================================================
    // State brought out for debug probing
    ctrl_state_e         ctrl_state;
    logic                block;
    logic [HEADER_W-1:0] header;
    logic                capture_start;
    logic                hdr_load;
    logic                hdr_phase;
    logic                pix_phase;
    logic                rd_start;
    logic                capture_done;
    logic                rd_done;

    // Datapath
    word_wr_t                wr;
    logic                    stat_sample;
    logic [PIXEL_W-1:0]      sample_pixel;
    logic [WORD_COUNT_W-1:0] wr_count;
    logic [STAT_W-1:0]       highlight_count;
    logic [STAT_W-1:0]       shadow_count;

    capture_ctrl u_ctrl (
        .clk           (clk),
        .fifoIn_rst    (fifoIn_rst),
        .cmd           (cmd),
        .img           (img),
        .rd_done       (rd_done),
        .state         (ctrl_state),
        .block         (block),
        .header        (header),
        .capture_start (capture_start),
        .hdr_load      (hdr_load),
        .hdr_phase     (hdr_phase),
        .pix_phase     (pix_phase),
        .rd_start      (rd_start),
        .capture_done  (capture_done)
    );

    pixel_framer u_framer (
        .clk          (clk),
        .fifoIn_rst   (fifoIn_rst),
        .img          (img),
        .header       (header),
        .hdr_load     (hdr_load),
        .hdr_phase    (hdr_phase),
        .pix_phase    (pix_phase),
        .wr           (wr),
        .stat_sample  (stat_sample),
        .sample_pixel (sample_pixel)
    );

    pixel_stats u_stats (
        .clk             (clk),
        .fifoIn_rst      (fifoIn_rst),
        .capture_start   (capture_start),
        .stat_sample     (stat_sample),
        .sample_pixel    (sample_pixel),
        .highlight_count (highlight_count),
        .shadow_count    (shadow_count)
    );

    frame_buffer u_buffer (
        .clk           (clk),
        .fifoIn_rst    (fifoIn_rst),
        .block         (block),
        .capture_start (capture_start),
        .wr            (wr),
        .rd_start      (rd_start),
        .wr_count      (wr_count),
        .readout       (readout),
        .rd_done       (rd_done)
    );

    // Status bundle
    assign status = '{
        capture_done:    capture_done,
        word_count:      wr_count,
        highlight_count: highlight_count,
        shadow_count:    shadow_count
    };

endmodule

`default_nettype wire

//--- src/pixel_framer.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_framer
    import img_ctrl_pkg::*;
(
    input  wire                  clk,
    input  wire                  fifoIn_rst,
    input  wire img_bus_t        img,
    input  wire [HEADER_W-1:0]   header,
    input  wire                  hdr_load,
    input  wire                  hdr_phase,
    input  wire                  pix_phase,
    output word_wr_t             wr,
    output logic                 stat_sample,
    output logic [PIXEL_W-1:0]   sample_pixel
);

    // Header shifter, top word goes first
    logic [HEADER_W-1:0] hdr_sr;

    // Sample grid position
    logic [1:0] col;
    logic [1:0] row;
    logic       lv_prev;

    // Pixel goes to storage
    logic store;

    // Registered write
    logic              wr_en_q;
    logic [WORD_W-1:0] wr_word_q;

    assign store = pix_phase && img.valid && img.lv;

    // Every 4th pixel of every 4th line
    assign stat_sample  = store && (col == 2'd0) && (row == 2'd0);
    assign sample_pixel = img.pixel;

    // ==================================================
    // Header shift
    // ==================================================
    always_ff @(posedge clk) begin
        if (hdr_load) begin
            hdr_sr <= header;
        end else if (hdr_phase) begin
            hdr_sr <= hdr_sr << WORD_W;
        end
    end

    // Column and row tracking
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            col     <= 2'd0;
            row     <= 2'd0;
            lv_prev <= 1'b0;
        end else if (img.valid) begin
            lv_prev <= img.lv;
            if (!img.lv) begin
                col <= 2'd0;
            end else if (store) begin
                col <= col + 2'd1;
            end
            // Advance on end of line
            if (!img.fv) begin
                row <= 2'd0;
            end else if (lv_prev && !img.lv) begin
                row <= row + 2'd1;
            end
        end
    end

    // ==================================================
    // Storage word select
    // ==================================================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            wr_en_q <= 1'b0;
        end else begin
            wr_en_q <= hdr_phase || store;
        end
    end

    always_ff @(posedge clk) begin
        if (hdr_phase) begin
            wr_word_q <= hdr_sr[HEADER_W-1 -: WORD_W];
        end else begin
            // Zero-extend pixel
            wr_word_q <= {{(WORD_W - PIXEL_W){1'b0}}, img.pixel};
        end
    end

    assign wr = '{en: wr_en_q, word: wr_word_q};

endmodule

`default_nettype wire

//--- src/pixel_stats.sv
`timescale 1ns/1ns
`default_nettype none

module pixel_stats
    import img_ctrl_pkg::*;
(
    input  wire                  clk,
    input  wire                  fifoIn_rst,
    input  wire                  capture_start,
    input  wire                  stat_sample,
    input  wire [PIXEL_W-1:0]    sample_pixel,
    output logic [STAT_W-1:0]    highlight_count,
    output logic [STAT_W-1:0]    shadow_count
);

    // Pipeline stage
    logic               sample_q;
    logic [PIXEL_W-1:0] pixel_q;

    // Classification bits
    logic [STAT_TOP_BITS-1:0] top_bits;

    assign top_bits = pixel_q[PIXEL_W-1 -: STAT_TOP_BITS];

    always_ff @(posedge clk) begin
        if (!fifoIn_rst) begin
            sample_q <= 1'b0;
        end else begin
            sample_q <= stat_sample;
        end
    end

    always_ff @(posedge clk) begin
        pixel_q <= sample_pixel;
    end

    // ==================================================
    // Saturating counters
    // ==================================================
    always_ff @(posedge clk) begin
        if (!fifoIn_rst || capture_start) begin
            highlight_count <= '0;
            shadow_count    <= '0;
        end else if (sample_q) begin
            // Top bits all set
            if ((&top_bits) && !(&highlight_count)) begin
                highlight_count <= highlight_count + 1'b1;
            end
            // Top bits all clear
            if (!(|top_bits) && !(&shadow_count)) begin
                shadow_count <= shadow_count + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- tests/tb_img_ctrl_checks.svh
`ifndef TB_IMG_CTRL_CHECKS_SVH
`define TB_IMG_CTRL_CHECKS_SVH

// ==================================================
// Failure exit
// ==================================================
task automatic stop_on_failure();
    $display("SOME TESTS FAILED");
    $fatal(1, "simulation stopped after the first failed check");
endtask

// Status fields shown as done/words/high/low
task automatic check_status(input string name, input status_t exp, input status_t act);
    if (act !== exp) begin
        $display("[ERROR] %s: expected %0b/%0d/%0d/%0d, actual %0b/%0d/%0d/%0d", name,
                 exp.capture_done, exp.word_count, exp.highlight_count, exp.shadow_count,
                 act.capture_done, act.word_count, act.highlight_count, act.shadow_count);
        stop_on_failure();
    end
endtask

task automatic check_word(input string name, input logic [WORD_W-1:0] exp,
                          input logic [WORD_W-1:0] act);
    if (act !== exp) begin
        $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
        stop_on_failure();
    end
endtask

task automatic check_state(input string name, input ctrl_state_e exp, input ctrl_state_e act);
    if (act !== exp) begin
        $display("[ERROR] %s: expected %s, actual %s (%0d)", name, exp.name(), act.name(), act);
        stop_on_failure();
    end
endtask

// Strobe counts and cycle offsets
task automatic check_count(input string name, input int exp, input int act);
    if (act != exp) begin
        $display("[ERROR] %s: expected %0d, actual %0d", name, exp, act);
        stop_on_failure();
    end
endtask

// ==================================================
// Bounded waits
// ==================================================
task automatic wait_for_state(input string name, input ctrl_state_e exp, input int limit);
    int n;
    n = 0;
    while (uut.ctrl_state != exp && n < limit) begin
        tick();
        n++;
    end
    if (uut.ctrl_state != exp) begin
        $display("Timeout: %s did not reach state %s within %0d cycles", name, exp.name(), limit);
        stop_on_failure();
    end
endtask

task automatic wait_for_done(input string name, input int limit);
    int n;
    n = 0;
    while (done_pulses == 0 && n < limit) begin
        tick();
        n++;
    end
    if (done_pulses == 0) begin
        $display("Timeout: %s never signalled capture done within %0d cycles", name, limit);
        stop_on_failure();
    end
endtask

`endif

//--- tests/tb_img_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module tb_img_ctrl
    import img_ctrl_pkg::*;
();

    // Pixel content of a test frame
    typedef enum logic [1:0] {
        PIX_RANDOM,
        PIX_HIGH,
        PIX_LOW
    } pix_mode_e;

    // One row of the frame table
    typedef struct packed {
        logic                block;
        logic [HEADER_W-1:0] header;
        logic [7:0]          rows;
        logic [7:0]          cols;
        pix_mode_e           mode;
        logic                poke;
    } frame_row_t;

    logic     clk;
    logic     fifoIn_rst;
    cmd_t     cmd;
    img_bus_t img;
    status_t  status;
    readout_t readout;

    integer seed;
    int     cyc;

    // Output monitor
    int                done_pulses;
    status_t           done_status;
    logic [WORD_W-1:0] rd_words[$];
    int                rd_first_cyc;
    int                rd_last_cyc;

    // Reference model of both blocks
    frame_row_t              frame_table [4];
    logic [WORD_W-1:0]       model_mem [BLOCK_COUNT][BLOCK_WORDS];
    int                      model_len [BLOCK_COUNT];
    logic [WORD_COUNT_W-1:0] last_count;

    img_ctrl_top uut (
        .clk        (clk),
        .fifoIn_rst (fifoIn_rst),
        .cmd        (cmd),
        .img        (img),
        .status     (status),
        .readout    (readout)
    );

    // 4 ns period
    always #2 clk = ~clk;

    `include "tb_img_ctrl_checks.svh"

    // ==================================================
    // Cycle step and monitor
    // ==================================================
    task automatic tick();
        @(posedge clk);
        #1;
        cyc++;
        if (status.capture_done) begin
            done_pulses++;
            done_status = status;
        end
        if (readout.valid) begin
            if (rd_words.size() == 0) begin
                rd_first_cyc = cyc;
            end
            rd_last_cyc = cyc;
            rd_words.push_back(readout.word);
        end
    endtask

    function automatic img_bus_t make_sample(input logic fv, input logic lv,
                                             input logic [PIXEL_W-1:0] pixel);
        img_bus_t s;
        s.valid = 1'b1;
        s.fv    = fv;
        s.lv    = lv;
        s.pixel = pixel;
        return s;
    endfunction

    // Highlight and shadow modes fix the top bits
    function automatic logic [PIXEL_W-1:0] pick_pixel(input pix_mode_e mode);
        logic [31:0] r;
        r = $random(seed);
        case (mode)
            PIX_HIGH: return {{STAT_TOP_BITS{1'b1}}, r[PIXEL_W-STAT_TOP_BITS-1:0]};
            PIX_LOW:  return {{STAT_TOP_BITS{1'b0}}, r[PIXEL_W-STAT_TOP_BITS-1:0]};
            default:  return r[PIXEL_W-1:0];
        endcase
    endfunction

    // ==================================================
    // Capture of one frame
    // ==================================================
    task automatic run_capture(input frame_row_t fr, input string name);
        img_bus_t           bus[$];
        logic [WORD_W-1:0]  words[$];
        logic [PIXEL_W-1:0] pix;
        status_t            exp_status;
        logic               poking;
        int                 nrows;
        int                 ncols;
        int                 hl;
        int                 sh;
        int                 poke_at;
        int                 gap;
        int                 k;
        int                 r;
        int                 c;
        nrows   = int'(fr.rows);
        ncols   = int'(fr.cols);
        hl      = 0;
        sh      = 0;
        poke_at = -1;

        // Header leads, top word first
        for (k = HEADER_WORDS - 1; k >= 0; k--) begin
            words.push_back(fr.header[k*WORD_W +: WORD_W]);
        end
        // Frame gap, then blank lines ahead of the first active line
        for (k = 0; k < 3; k++) begin
            bus.push_back(make_sample(1'b0, 1'b0, '0));
        end
        for (k = 0; k < 8; k++) begin
            bus.push_back(make_sample(1'b1, 1'b0, '0));
        end
        for (r = 0; r < nrows; r++) begin
            for (c = 0; c < ncols; c++) begin
                pix = pick_pixel(fr.mode);
                if (fr.poke && r == nrows / 2 && c == 1) begin
                    poke_at = bus.size();
                end
                bus.push_back(make_sample(1'b1, 1'b1, pix));
                words.push_back(WORD_W'(pix));
                // Every 4th pixel of every 4th line
                if (r % 4 == 0 && c % 4 == 0) begin
                    if (pix[PIXEL_W-1 -: STAT_TOP_BITS] == '1) begin
                        hl++;
                    end
                    if (pix[PIXEL_W-1 -: STAT_TOP_BITS] == '0) begin
                        sh++;
                    end
                end
            end
            // Line blanking
            bus.push_back(make_sample(1'b1, 1'b0, '0));
            bus.push_back(make_sample(1'b1, 1'b0, '0));
        end
        // Closes the frame
        bus.push_back(make_sample(1'b0, 1'b0, '0));

        done_pulses = 0;
        rd_words.delete();
        cmd = '{capture: 1'b1, readout: 1'b0, block: fr.block, header: fr.header};
        tick();
        cmd = '0;

        foreach (bus[i]) begin
            // Random idle cycles between samples
            gap = $unsigned($random(seed)) % 3;
            repeat (gap) begin
                img.valid = 1'b0;
                tick();
            end
            img = bus[i];
            // Commands in mid frame must bounce off, capture then readout
            poking = fr.poke && (i == poke_at || i == poke_at + 1);
            if (poking) begin
                check_state({name, " before poke"}, PIXELS, uut.ctrl_state);
                if (i == poke_at) begin
                    cmd = '{capture: 1'b1, readout: 1'b0, block: ~fr.block, header: ~fr.header};
                end else begin
                    cmd = '{capture: 1'b0, readout: 1'b1, block: ~fr.block, header: '0};
                end
            end
            tick();
            cmd = '0;
            if (poking) begin
                check_state({name, " after poke"}, PIXELS, uut.ctrl_state);
            end
        end
        img.valid = 1'b0;
        wait_for_done(name, 50);
        repeat (6) begin
            tick();
        end

        check_count({name, " done pulses"}, 1, done_pulses);
        check_count({name, " readout strobes during capture"}, 0, rd_words.size());
        check_state({name, " end state"}, IDLE, uut.ctrl_state);
        exp_status = '{capture_done: 1'b1, word_count: WORD_COUNT_W'(words.size()),
                       highlight_count: STAT_W'(hl), shadow_count: STAT_W'(sh)};
        check_status(name, exp_status, done_status);

        // A shorter frame leaves the older tail of the block in place
        foreach (words[w]) begin
            model_mem[fr.block][w] = words[w];
        end
        if (words.size() > model_len[fr.block]) begin
            model_len[fr.block] = words.size();
        end
        last_count = WORD_COUNT_W'(words.size());
    endtask

    // ==================================================
    // Readout of one block
    // ==================================================
    task automatic run_readout(input logic blk, input string name);
        int n;
        int cmd_cyc;
        n = int'(last_count);
        rd_words.delete();
        cmd = '{capture: 1'b0, readout: 1'b1, block: blk, header: '0};
        cmd_cyc = cyc;
        tick();
        cmd = '0;
        check_state({name, " start state"}, READOUT, uut.ctrl_state);
        wait_for_state(name, IDLE, n + 20);
        repeat (3) begin
            tick();
        end

        check_count({name, " word strobes"}, n, rd_words.size());
        if (n > 0) begin
            check_count({name, " first word latency"}, 2, rd_first_cyc - cmd_cyc);
            // Back to back, one word per cycle
            check_count({name, " stream span"}, n - 1, rd_last_cyc - rd_first_cyc);
        end
        foreach (rd_words[i]) begin
            check_word($sformatf("%s word %0d", name, i), model_mem[blk][i], rd_words[i]);
        end
    endtask

    // ==================================================
    // Test sequence
    // ==================================================
    initial begin
        logic other;
        clk          = 1'b0;
        fifoIn_rst   = 1'b0;
        cmd          = '0;
        img          = '0;
        seed         = 32'h7827;
        cyc          = 0;
        done_pulses  = 0;
        rd_first_cyc = 0;
        rd_last_cyc  = 0;
        last_count   = '0;
        model_len[0] = 0;
        model_len[1] = 0;

        // block, header, rows, cols, pixel mode, mid-frame command
        frame_table[0] = '{1'b0, 64'hA5A5_0123_4567_89AB, 8'd8, 8'd12, PIX_RANDOM, 1'b0};
        frame_table[1] = '{1'b1, 64'h5A5A_FEDC_BA98_7654, 8'd6, 8'd10, PIX_HIGH, 1'b1};
        frame_table[2] = '{1'b0, 64'h0F0F_1357_9BDF_2468, 8'd5, 8'd7, PIX_LOW, 1'b0};
        frame_table[3] = '{1'b1, 64'hF0F0_8642_ECA8_1357, 8'd7, 8'd9, PIX_RANDOM, 1'b1};

        repeat (5) begin
            @(posedge clk);
        end
        #1;
        fifoIn_rst = 1'b1;

        // Quiet after reset
        tick();
        check_status("reset status", '0, status);
        check_state("reset state", IDLE, uut.ctrl_state);
        repeat (4) begin
            tick();
        end
        check_count("reset readout strobes", 0, rd_words.size());
        check_count("reset done pulses", 0, done_pulses);
        run_readout(1'b0, "empty readout");

        foreach (frame_table[i]) begin
            run_capture(frame_table[i], $sformatf("frame %0d", i));
            run_readout(frame_table[i].block, $sformatf("frame %0d readout", i));
            // Other block, only where it holds enough words
            other = ~frame_table[i].block;
            if (model_len[other] >= int'(last_count)) begin
                run_readout(other, $sformatf("frame %0d other block", i));
            end
        end

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+tests
src/img_ctrl_pkg.sv
src/capture_ctrl.sv
src/pixel_framer.sv
src/pixel_stats.sv
src/frame_buffer.sv
src/img_ctrl_top.sv
tests/tb_img_ctrl.sv
